// ==== design/audioCodecPkg.sv ====
// Audio codec package: sample width, control word union, device address, config table

package audioCodecPkg;

	localparam int SAMPLE_W = 16;

	// Codec control word with a 7-bit register address above 9-bit data
	typedef struct packed {
		logic [6:0] regAddr;
		logic [8:0] regData;
	} codecFields_t;

	typedef union packed {
		logic [15:0]  raw;
		codecFields_t fields;
	} codecWord_u;

	localparam logic [7:0] CODEC_DEV_ADDR = 8'h34;

	localparam int CONFIG_LEN = 10;

	function automatic codecWord_u makeWord(input logic [6:0] addr, input logic [8:0] data);
		codecWord_u word;
		word.fields.regAddr = addr;
		word.fields.regData = data;
		return word;
	endfunction

	// Line-in uses the both-channels bit, so one entry sets left and right
	localparam codecWord_u CONFIG_TABLE [CONFIG_LEN] = '{
		makeWord(7'h0F, 9'h000),  // Reset
		makeWord(7'h00, 9'h117),  // Line-in left and right, 0 dB
		makeWord(7'h02, 9'h079),  // Headphone left
		makeWord(7'h03, 9'h079),  // Headphone right
		makeWord(7'h04, 9'h012),  // Analog path, DAC on, line-in to ADC
		makeWord(7'h05, 9'h006),  // Digital path, 48 kHz de-emphasis
		makeWord(7'h06, 9'h000),  // Power everything up
		makeWord(7'h07, 9'h001),  // Left-justified, 16 bit, slave
		makeWord(7'h08, 9'h001),  // USB mode, 48 kHz
		makeWord(7'h09, 9'h001)   // Activate
	};

endpackage

// ==== design/codecSerialPort.sv ====
// Serial audio port: BCK/LRCK generation, DAC shift-out, ADC capture

`timescale 1ns/1ps

module codecSerialPort #(
	parameter int pFrameWait = 93
) (
	input  logic                              iCLK,
	input  logic                              iRST_N,
	input  logic                              iEnable,
	input  logic [audioCodecPkg::SAMPLE_W-1:0] iPlayL,
	input  logic [audioCodecPkg::SAMPLE_W-1:0] iPlayR,
	input  logic                              iAudAdcData,
	output logic                              oAudBck,
	output logic                              oAudLrck,
	output logic                              oAudDacData,
	output logic                              oCapValid,
	output logic [audioCodecPkg::SAMPLE_W-1:0] oCapL,
	output logic [audioCodecPkg::SAMPLE_W-1:0] oCapR
);

	localparam int SW = audioCodecPkg::SAMPLE_W;
	localparam int IDX_W = $clog2(SW);
	localparam int WAIT_W = (pFrameWait > 1) ? $clog2(pFrameWait) : 1;
	localparam logic [IDX_W-1:0] BIT_LAST = IDX_W'(SW - 1);
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(pFrameWait - 1);

	// Sequencer state
	logic              sendPhase;
	logic              inWait;
	logic              rightCh;
	logic [IDX_W-1:0]  bitIdx;
	logic [WAIT_W-1:0] waitCnt;

	// Sample registers
	logic [SW-1:0] playWord;
	logic [SW-1:0] shiftL;
	logic [SW-1:0] shiftR;

	logic [SW-1:0] playSel;
	logic          setupCycle;
	logic          sendCycle;
	logic          halfStart;

	assign playSel    = rightCh ? iPlayR : iPlayL;
	assign setupCycle = !inWait && !sendPhase;
	assign sendCycle  = !inWait && sendPhase;
	assign halfStart  = setupCycle && (bitIdx == '0);

	//////////////////////////////////////////////////////////////////////
	// Frame sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iCLK or negedge iRST_N) begin
		if (!iRST_N) begin
			sendPhase   <= 1'b0;
			inWait      <= 1'b0;
			rightCh     <= 1'b0;
			bitIdx      <= '0;
			waitCnt     <= '0;
			oAudBck     <= 1'b0;
			oAudLrck    <= 1'b0;
			oAudDacData <= 1'b0;
			oCapValid   <= 1'b0;
		end else begin
			oCapValid <= 1'b0;
			if (inWait) begin
				if (waitCnt == WAIT_LAST) begin
					waitCnt <= '0;
					inWait  <= 1'b0;
					rightCh <= ~rightCh;
				end else begin
					waitCnt <= waitCnt + 1'b1;
				end
			end else if (!sendPhase) begin
				oAudBck <= 1'b0;
				if (halfStart && !rightCh && !iEnable) begin
					// Parked at the start of a left half
					oAudDacData <= 1'b0;
				end else if (halfStart) begin
					oAudLrck    <= ~rightCh;
					oAudDacData <= playSel[SW-1];
					sendPhase   <= 1'b1;
				end else begin
					oAudDacData <= playWord[BIT_LAST - bitIdx];
					sendPhase   <= 1'b1;
				end
			end else begin
				oAudBck   <= 1'b1;
				sendPhase <= 1'b0;
				bitIdx    <= bitIdx + 1'b1;
				if (bitIdx == BIT_LAST) begin
					inWait <= 1'b1;
					if (rightCh)
						oCapValid <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sample data path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iCLK) begin
		if (halfStart)
			playWord <= playSel;
		if (sendCycle) begin
			if (rightCh)
				shiftR <= {shiftR[SW-2:0], iAudAdcData};
			else
				shiftL <= {shiftL[SW-2:0], iAudAdcData};
			// Publish the pair with the last right bit
			if (rightCh && bitIdx == BIT_LAST) begin
				oCapL <= shiftL;
				oCapR <= {shiftR[SW-2:0], iAudAdcData};
			end
		end
	end

	// LRCK may only move while the bit clock is low
	lrckOnLowBck: assert property (@(posedge iCLK) disable iff (!iRST_N)
		$changed(oAudLrck) |-> !oAudBck);

	capValidPulse: assert property (@(posedge iCLK) disable iff (!iRST_N)
		oCapValid |=> !oCapValid);

endmodule

// ==== design/codecConfigWriter.sv ====
// Two-wire bus master that writes the codec configuration table once after reset

`timescale 1ns/1ps

module codecConfigWriter #(
	parameter int pSclkDiv = 30
) (
	input  logic iCLK,
	input  logic iRST_N,
	input  logic iSdat,
	output logic oSclk,
	output logic oSdat,
	output logic oDone,
	output logic oError
);

	localparam int DIV_W = (pSclkDiv > 1) ? $clog2(pSclkDiv) : 1;
	localparam int IDX_W = $clog2(audioCodecPkg::CONFIG_LEN);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(pSclkDiv - 1);
	localparam logic [IDX_W-1:0] ENTRY_LAST = IDX_W'(audioCodecPkg::CONFIG_LEN - 1);

	// 27 slots of address, ack, high byte, ack, low byte and ack
	localparam logic [4:0] SLOT_LAST = 5'd26;
	localparam logic [4:0] ACK_PREV0 = 5'd7;
	localparam logic [4:0] ACK_PREV1 = 5'd16;
	localparam logic [4:0] ACK_PREV2 = 5'd25;

	localparam logic [2:0] PH_START = 3'd0;
	localparam logic [2:0] PH_SHIFT = 3'd1;
	localparam logic [2:0] PH_ACK   = 3'd2;
	localparam logic [2:0] PH_STOP  = 3'd3;
	localparam logic [2:0] PH_NEXT  = 3'd4;
	localparam logic [2:0] PH_DONE  = 3'd5;

	logic [2:0]       phase;
	logic [1:0]       quarter;
	logic [DIV_W-1:0] divCnt;
	logic [4:0]       bitCnt;
	logic [IDX_W-1:0] entryIdx;

	audioCodecPkg::codecWord_u curWord;
	logic [26:0] txFrame;
	logic        quarterTick;
	logic        nextIsAck;
	logic        sclkNext;
	logic        sdatNext;

	assign curWord     = audioCodecPkg::CONFIG_TABLE[entryIdx];
	// Ack slots carry a 1 so the line is released
	assign txFrame     = {audioCodecPkg::CODEC_DEV_ADDR, 1'b1,
		curWord.raw[15:8], 1'b1, curWord.raw[7:0], 1'b1};
	assign quarterTick = (divCnt == DIV_LAST);
	assign nextIsAck   = (bitCnt == ACK_PREV0) || (bitCnt == ACK_PREV1) ||
		(bitCnt == ACK_PREV2);

	//////////////////////////////////////////////////////////////////////
	// Line levels per phase and quarter
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sclkNext = 1'b1;
		sdatNext = 1'b1;
		case (phase)
			PH_START: begin
				sclkNext = (quarter != 2'd3);
				sdatNext = (quarter < 2'd2);
			end
			PH_SHIFT, PH_ACK: begin
				sclkNext = (quarter == 2'd1) || (quarter == 2'd2);
				sdatNext = txFrame[SLOT_LAST - bitCnt];
			end
			PH_STOP: begin
				sclkNext = (quarter != 2'd0);
				sdatNext = (quarter >= 2'd2);
			end
			default: begin
				sclkNext = 1'b1;
				sdatNext = 1'b1;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Transaction sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iCLK or negedge iRST_N) begin
		if (!iRST_N) begin
			phase    <= PH_START;
			quarter  <= 2'd0;
			divCnt   <= '0;
			bitCnt   <= '0;
			entryIdx <= '0;
			oSclk    <= 1'b1;
			oSdat    <= 1'b1;
			oDone    <= 1'b0;
			oError   <= 1'b0;
		end else begin
			oSclk <= sclkNext;
			oSdat <= sdatNext;
			if (phase == PH_NEXT) begin
				if (entryIdx == ENTRY_LAST) begin
					phase <= PH_DONE;
					oDone <= 1'b1;
				end else begin
					entryIdx <= entryIdx + 1'b1;
					phase    <= PH_START;
				end
			end else if (phase != PH_DONE) begin
				if (quarterTick) begin
					divCnt  <= '0;
					quarter <= quarter + 1'b1;
					// Ack sampled mid-way through SCLK high
					if (phase == PH_ACK && quarter == 2'd1 && iSdat)
						oError <= 1'b1;
					if (quarter == 2'd3) begin
						case (phase)
							PH_START: begin
								bitCnt <= '0;
								phase  <= PH_SHIFT;
							end
							PH_SHIFT, PH_ACK: begin
								if (bitCnt == SLOT_LAST) begin
									phase <= PH_STOP;
								end else begin
									bitCnt <= bitCnt + 1'b1;
									phase  <= nextIsAck ? PH_ACK : PH_SHIFT;
								end
							end
							default:
								phase <= PH_NEXT;
						endcase
					end
				end else begin
					divCnt <= divCnt + 1'b1;
				end
			end
		end
	end

	// Data may only move under SCLK high for START and STOP
	sdatStable: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(oSclk && $changed(oSdat)) |-> (phase == PH_START || phase == PH_STOP));

endmodule

// ==== design/audioCodecTop.sv ====
// Audio codec top level: configuration writer and serial audio port

`timescale 1ns/1ps

module audioCodecTop #(
	parameter int pFrameWait = 93,
	parameter int pSclkDiv   = 30
) (
	input  logic                              iCLK,
	input  logic                              iRST_N,
	input  logic [audioCodecPkg::SAMPLE_W-1:0] iPlayL,
	input  logic [audioCodecPkg::SAMPLE_W-1:0] iPlayR,
	output logic [audioCodecPkg::SAMPLE_W-1:0] oCapL,
	output logic [audioCodecPkg::SAMPLE_W-1:0] oCapR,
	output logic                              oCapValid,
	output logic                              oAudBck,
	output logic                              oAudLrck,
	output logic                              oAudDacData,
	input  logic                              iAudAdcData,
	output logic                              oI2cSclk,
	output logic                              oI2cSdat,
	input  logic                              iI2cSdat,
	output logic                              oConfigDone,
	output logic                              oConfigError
);

	// Codec register setup over the two-wire bus
	codecConfigWriter #(
		.pSclkDiv (pSclkDiv)
	) configWriter (
		.iCLK   (iCLK),
		.iRST_N (iRST_N),
		.iSdat  (iI2cSdat),
		.oSclk  (oI2cSclk),
		.oSdat  (oI2cSdat),
		.oDone  (oConfigDone),
		.oError (oConfigError)
	);

	// Audio frames start once the codec is configured
	codecSerialPort #(
		.pFrameWait (pFrameWait)
	) serialPort (
		.iCLK        (iCLK),
		.iRST_N      (iRST_N),
		.iEnable     (oConfigDone),
		.iPlayL      (iPlayL),
		.iPlayR      (iPlayR),
		.iAudAdcData (iAudAdcData),
		.oAudBck     (oAudBck),
		.oAudLrck    (oAudLrck),
		.oAudDacData (oAudDacData),
		.oCapValid   (oCapValid),
		.oCapL       (oCapL),
		.oCapR       (oCapR)
	);

endmodule

// ==== verification/codecBusModel.sv ====
// Behavioral codec: two-wire write decoder with ACK, DAC bit collector, ADC serializer

`timescale 1ns/1ps

module codecBusModel (
	input  logic        iCLK,
	input  logic        iRST_N,
	input  logic        sclk,
	input  logic        sdatLine,
	input  int          nackIndex,
	output logic        sdatPull,
	output int          wordCount,
	output audioCodecPkg::codecWord_u words [16],
	output logic [7:0]  devAddrs [16],
	input  logic        bck,
	input  logic        lrck,
	input  logic        dacData,
	input  logic [15:0] adcL,
	input  logic [15:0] adcR,
	output logic        adcData,
	output logic [15:0] dacL,
	output logic [15:0] dacR
);

	logic       sclkPrev;
	logic       sdatPrev;
	logic       active;
	logic       acking;
	logic       bckPrev;
	logic [7:0] shiftReg;
	logic [7:0] rxBytes [3];
	logic [3:0] bitCnt;
	logic [1:0] byteCnt;
	logic [4:0] cntL;
	logic [4:0] cntR;
	logic [15:0] adcLShift;
	logic [15:0] adcRShift;

	// Next ADC bit follows the BCK rise count within the current LRCK level
	assign adcLShift = adcL << cntL;
	assign adcRShift = adcR << cntR;
	assign adcData   = lrck ? adcLShift[15] : adcRShift[15];

	//////////////////////////////////////////////////////////////////////
	// Two-wire write decoder
	//////////////////////////////////////////////////////////////////////

	always @(posedge iCLK or negedge iRST_N) begin
		if (!iRST_N) begin
			sclkPrev  <= 1'b1;
			sdatPrev  <= 1'b1;
			active    <= 1'b0;
			acking    <= 1'b0;
			sdatPull  <= 1'b0;
			bitCnt    <= '0;
			byteCnt   <= '0;
			wordCount <= 0;
		end else begin
			sclkPrev <= sclk;
			sdatPrev <= sdatLine;
			if (sclk && sclkPrev && sdatPrev && !sdatLine) begin
				// START
				active  <= 1'b1;
				bitCnt  <= '0;
				byteCnt <= '0;
			end else if (sclk && sclkPrev && !sdatPrev && sdatLine) begin
				active <= 1'b0;
				if (active && byteCnt == 2'd3 && wordCount < 16) begin
					words[wordCount].raw <= {rxBytes[1], rxBytes[2]};
					devAddrs[wordCount]  <= rxBytes[0];
					wordCount            <= wordCount + 1;
				end
			end else if (active && sclk && !sclkPrev && bitCnt < 4'd8) begin
				shiftReg <= {shiftReg[6:0], sdatLine};
				bitCnt   <= bitCnt + 1'b1;
			end else if (active && !sclk && sclkPrev) begin
				if (acking) begin
					sdatPull <= 1'b0;
					acking   <= 1'b0;
					bitCnt   <= '0;
					byteCnt  <= byteCnt + 1'b1;
				end else if (bitCnt == 4'd8) begin
					rxBytes[byteCnt] <= shiftReg;
					sdatPull         <= (wordCount != nackIndex);
					acking           <= 1'b1;
				end
			end
		end
	end

	// DAC bits by LRCK level on each BCK rise
	always @(posedge iCLK or negedge iRST_N) begin
		if (!iRST_N) begin
			bckPrev <= 1'b0;
			cntL    <= '0;
			cntR    <= '0;
		end else begin
			bckPrev <= bck;
			if (bck && !bckPrev) begin
				if (lrck) begin
					dacL <= {dacL[14:0], dacData};
					cntL <= cntL + 1'b1;
					cntR <= '0;
				end else begin
					dacR <= {dacR[14:0], dacData};
					cntR <= cntR + 1'b1;
					cntL <= '0;
				end
			end
		end
	end

endmodule

// ==== verification/audioCodecTb.sv ====
// Testbench: clock, reset, stimulus table loop, configuration, audio path and frame checks

`timescale 1ns/1ps

module audioCodecTb;

	localparam int SW = audioCodecPkg::SAMPLE_W;
	localparam int SCLK_DIV = 4;
	localparam int FRAME_CYCLES = 250;
	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT_CYCLES =
		(2 * audioCodecPkg::CONFIG_LEN * 29 * 4 * SCLK_DIV + 10 * FRAME_CYCLES) * 5 / 4;

	logic          iCLK;
	logic          iRST_N;
	logic [SW-1:0] playL;
	logic [SW-1:0] playR;
	logic [SW-1:0] adcL;
	logic [SW-1:0] adcR;
	logic [SW-1:0] capL;
	logic [SW-1:0] capR;
	logic          capValid;
	logic          bck;
	logic          lrck;
	logic          dacData;
	logic          adcData;
	logic          sclk;
	logic          sdat;
	logic          sdatPull;
	logic          sdatLine;
	logic          done;
	logic          error;
	logic [15:0]   dacL;
	logic [15:0]   dacR;
	int            nackIndex;
	int            wordCount;
	int            cycleCount;
	integer        seed;
	audioCodecPkg::codecWord_u words [16];
	logic [7:0]    devAddrs [16];

	// Columns hold playL, playR, adcL and adcR
	logic [SW-1:0] stimTab [NUM_ROWS][4];

	// Frame monitor state
	logic bckPrev;
	logic lrckPrev;
	logic levelSeen;
	logic riseSeen;
	int   riseCount;
	int   pulseCount;
	int   sinceRise;

	assign sdatLine = sdat & ~sdatPull;

	audioCodecTop #(
		.pSclkDiv (SCLK_DIV)
	) UUT (
		.iCLK         (iCLK),
		.iRST_N       (iRST_N),
		.iPlayL       (playL),
		.iPlayR       (playR),
		.oCapL        (capL),
		.oCapR        (capR),
		.oCapValid    (capValid),
		.oAudBck      (bck),
		.oAudLrck     (lrck),
		.oAudDacData  (dacData),
		.iAudAdcData  (adcData),
		.oI2cSclk     (sclk),
		.oI2cSdat     (sdat),
		.iI2cSdat     (sdatLine),
		.oConfigDone  (done),
		.oConfigError (error)
	);

	codecBusModel codecModel (
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.sclk      (sclk),
		.sdatLine  (sdatLine),
		.nackIndex (nackIndex),
		.sdatPull  (sdatPull),
		.wordCount (wordCount),
		.words     (words),
		.devAddrs  (devAddrs),
		.bck       (bck),
		.lrck      (lrck),
		.dacData   (dacData),
		.adcL      (adcL),
		.adcR      (adcR),
		.adcData   (adcData),
		.dacL      (dacL),
		.dacR      (dacR)
	);

	initial begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	task automatic flagMismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
		$display("SIMULATION FAILED");
		$fatal(1, "Value check failed");
	endtask

	task automatic stopWithMessage(input string msg);
		$display("Error: %s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "Check failed");
	endtask

	task automatic applyReset();
		iRST_N <= 1'b0;
		repeat (3) @(posedge iCLK);
		iRST_N <= 1'b1;
	endtask

	task automatic loadRow(input int r);
		playL <= stimTab[r][0];
		playR <= stimTab[r][1];
		adcL  <= stimTab[r][2];
		adcR  <= stimTab[r][3];
	endtask

	task automatic waitConfigDone();
		while (!done)
			@(posedge iCLK);
	endtask

	task automatic checkConfigWords();
		assert (wordCount == audioCodecPkg::CONFIG_LEN)
			else flagMismatch("wordCount", wordCount, audioCodecPkg::CONFIG_LEN);
		for (int i = 0; i < audioCodecPkg::CONFIG_LEN; i++) begin
			assert (words[i].fields.regAddr == audioCodecPkg::CONFIG_TABLE[i].fields.regAddr)
				else flagMismatch($sformatf("words[%0d].regAddr", i),
					words[i].fields.regAddr, audioCodecPkg::CONFIG_TABLE[i].fields.regAddr);
			assert (words[i].fields.regData == audioCodecPkg::CONFIG_TABLE[i].fields.regData)
				else flagMismatch($sformatf("words[%0d].regData", i),
					words[i].fields.regData, audioCodecPkg::CONFIG_TABLE[i].fields.regData);
			assert (devAddrs[i] == audioCodecPkg::CODEC_DEV_ADDR)
				else flagMismatch($sformatf("devAddrs[%0d]", i), devAddrs[i],
					audioCodecPkg::CODEC_DEV_ADDR);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame timing and idle monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge iCLK) begin
		if (!iRST_N) begin
			levelSeen  <= 1'b0;
			riseSeen   <= 1'b0;
			riseCount  <= 0;
			pulseCount <= 0;
			sinceRise  <= 0;
		end else begin
			if (!done)
				assert (!bck && !lrck && !capValid)
					else stopWithMessage("serial port active before configuration was done");
			if (bck && !bckPrev)
				riseCount <= riseCount + 1;
			if (capValid)
				pulseCount <= pulseCount + 1;
			sinceRise <= sinceRise + 1;
			if (lrck != lrckPrev) begin
				if (levelSeen)
					assert (riseCount == 16) else flagMismatch("BCK rises per level", riseCount, 16);
				levelSeen <= 1'b1;
				riseCount <= 0;
			end
			if (lrck && !lrckPrev) begin
				if (riseSeen) begin
					assert (sinceRise == FRAME_CYCLES)
						else flagMismatch("LRCK period", sinceRise, FRAME_CYCLES);
					assert (pulseCount == 1) else flagMismatch("oCapValid per frame", pulseCount, 1);
				end
				riseSeen   <= 1'b1;
				sinceRise  <= 1;
				pulseCount <= 0;
			end
		end
		bckPrev  <= bck;
		lrckPrev <= lrck;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge iCLK);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$fatal(1, "Timeout");
	end

	initial begin
		seed = 32'h4a27;
		for (int r = 0; r < NUM_ROWS; r++)
			for (int c = 0; c < 4; c++)
				stimTab[r][c] = SW'($random(seed));
		nackIndex <= -1;
		loadRow(0);
		applyReset();
		waitConfigDone();
		checkConfigWords();
		assert (!error) else flagMismatch("oConfigError", error, 0);

		// One row per frame
		for (int r = 0; r < NUM_ROWS; r++) begin
			do
				@(posedge iCLK);
			while (!capValid);
			assert (capL == stimTab[r][2]) else flagMismatch("oCapL", capL, stimTab[r][2]);
			assert (capR == stimTab[r][3]) else flagMismatch("oCapR", capR, stimTab[r][3]);
			@(posedge iCLK);
			assert (dacL == stimTab[r][0]) else flagMismatch("DAC left word", dacL, stimTab[r][0]);
			assert (dacR == stimTab[r][1]) else flagMismatch("DAC right word", dacR, stimTab[r][1]);
			if (r + 1 < NUM_ROWS)
				loadRow(r + 1);
		end

		// Second run, codec refuses entry 3
		nackIndex <= 3;
		applyReset();
		waitConfigDone();
		assert (error) else flagMismatch("oConfigError", error, 1);
		assert (wordCount == audioCodecPkg::CONFIG_LEN)
			else flagMismatch("wordCount", wordCount, audioCodecPkg::CONFIG_LEN);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
design/audioCodecPkg.sv
design/codecSerialPort.sv
design/codecConfigWriter.sv
design/audioCodecTop.sv
verification/codecBusModel.sv
verification/audioCodecTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the audio codec testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module audioCodecTb \
	-f sources.f -o simAudioCodec

./obj_dir/simAudioCodec > sim.log 2>&1 || true
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
